// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction byte held by the IR
`define CPU_INS_WIDTH 8

// wide enough for every sequencer state
`define CPU_STATE_WIDTH 6

// low nibble of a register move; the high nibble picks the move
`define CPU_MV_LOW 4'd15

`endif

// ==== logic/controlPkg.sv ====
`include "cpu_settings.svh"

package controlPkg;

    typedef enum logic [4:0] {
        OP_NOP      = 5'd0,
        OP_END      = 5'd1,
        OP_CLAC     = 5'd2,
        OP_LDIAC    = 5'd3,
        OP_LDAC     = 5'd4,
        OP_STR      = 5'd5,
        OP_STIR     = 5'd6,
        OP_JUMP     = 5'd7,
        OP_JMPNZ    = 5'd8,
        OP_JMPZ     = 5'd9,
        OP_MUL      = 5'd10,
        OP_ADD      = 5'd11,
        OP_SUB      = 5'd12,
        OP_INCAC    = 5'd13,
        OP_MV_RL_AC = 5'd14,   // moves follow the high nibble, 1 to 9
        OP_MV_RP_AC = 5'd15,
        OP_MV_RQ_AC = 5'd16,
        OP_MV_RC_AC = 5'd17,
        OP_MV_R_AC  = 5'd18,
        OP_MV_R1_AC = 5'd19,
        OP_MV_AC_RP = 5'd20,
        OP_MV_AC_RQ = 5'd21,
        OP_MV_AC_RL = 5'd22,
        OP_ILLEGAL  = 5'd31
    } opcode_t;

    typedef enum logic [`CPU_STATE_WIDTH-1:0] {
        S_IDLE, S_FETCH, S_DECODE,
        S_NOP1, S_END1, S_CLAC1,
        S_LDIAC1, S_LDIAC2, S_LDIAC3,
        S_LDAC1, S_LDAC2,
        S_STR1, S_STR2,
        S_STIR1, S_STIR2, S_STIR3,
        S_JUMP1, S_JUMP2,
        S_JMPNZY1, S_JMPNZY2, S_JMPNZN1,
        S_JMPZY1, S_JMPZY2, S_JMPZN1,
        S_MUL1, S_ADD1, S_SUB1, S_INCAC1,
        S_MV_RL_AC1, S_MV_RP_AC1, S_MV_RQ_AC1, S_MV_RC_AC1, S_MV_R_AC1, S_MV_R1_AC1,
        S_MV_AC_RP1, S_MV_AC_RQ1, S_MV_AC_RL1
    } state_t;

    typedef enum logic [2:0] {
        ALU_IDLE, ALU_CLR, ALU_PASS, ALU_ADD, ALU_SUB, ALU_MUL, ALU_INC
    } aluOp_t;

    typedef enum logic [3:0] {
        BUS_IDLE, BUS_DMEM, BUS_IR, BUS_AC, BUS_R1, BUS_R, BUS_RC, BUS_RP, BUS_RQ, BUS_RL
    } busSel_t;

    typedef struct packed {
        logic pc;
        logic rc;
        logic rp;
        logic rq;
    } incSel_t;

    typedef struct packed {
        logic ar;
        logic r;
        logic pc;
        logic ir;
        logic rl;
        logic rc;
        logic rp;
        logic rq;
        logic r1;
        logic ac;
    } wrEnSel_t;

    typedef struct packed {
        aluOp_t   aluOp;
        incSel_t  inc;
        wrEnSel_t wrEn;
        busSel_t  busSel;
        logic     dataMemWrEn;
        logic     zWrEn;
    } ctrlWord_t;

    parameter ctrlWord_t IDLE_WORD = '{
        aluOp:       ALU_IDLE,
        inc:         '0,
        wrEn:        '0,
        busSel:      BUS_IDLE,
        dataMemWrEn: 1'b0,
        zWrEn:       1'b0
    };

endpackage

// ==== logic/opcodeDecoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module opcodeDecoder (
    input  logic [`CPU_INS_WIDTH-1:0] ins,
    output controlPkg::opcode_t       opcode
);
    import controlPkg::*;

    logic [3:0] hiNib;
    logic [3:0] loNib;
    logic       isMove;

    assign hiNib = ins[`CPU_INS_WIDTH-1 -: 4];
    assign loNib = ins[3:0];

    // move group: low nibble fixed, high nibble 1..9
    assign isMove = (loNib == `CPU_MV_LOW) && (hiNib >= 4'd1) && (hiNib <= 4'd9);

    always_comb begin
        opcode = OP_ILLEGAL;
        if (ins <= `CPU_INS_WIDTH'(13)) begin
            opcode = opcode_t'(ins[4:0]);   // plain codes map one to one
        end
        else if (isMove) begin
            opcode = opcode_t'({1'b0, hiNib} + 5'd13);
        end
    end

endmodule

// ==== logic/sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                zOut,
    input  controlPkg::opcode_t opcode,
    output controlPkg::state_t  state
);
    import controlPkg::*;

    state_t nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= S_IDLE;
        end
        else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = S_IDLE;
        case (state)
            S_IDLE:   nextState = start ? S_FETCH : S_IDLE;
            S_FETCH:  nextState = S_DECODE;

            S_DECODE: begin
                case (opcode)
                    OP_NOP:      nextState = S_NOP1;
                    OP_END:      nextState = S_END1;
                    OP_CLAC:     nextState = S_CLAC1;
                    OP_LDIAC:    nextState = S_LDIAC1;
                    OP_LDAC:     nextState = S_LDAC1;
                    OP_STR:      nextState = S_STR1;
                    OP_STIR:     nextState = S_STIR1;
                    OP_JUMP:     nextState = S_JUMP1;
                    OP_JMPNZ:    nextState = !zOut ? S_JMPNZY1 : S_JMPNZN1;
                    OP_JMPZ:     nextState = zOut ? S_JMPZY1 : S_JMPZN1;
                    OP_MUL:      nextState = S_MUL1;
                    OP_ADD:      nextState = S_ADD1;
                    OP_SUB:      nextState = S_SUB1;
                    OP_INCAC:    nextState = S_INCAC1;
                    OP_MV_RL_AC: nextState = S_MV_RL_AC1;
                    OP_MV_RP_AC: nextState = S_MV_RP_AC1;
                    OP_MV_RQ_AC: nextState = S_MV_RQ_AC1;
                    OP_MV_RC_AC: nextState = S_MV_RC_AC1;
                    OP_MV_R_AC:  nextState = S_MV_R_AC1;
                    OP_MV_R1_AC: nextState = S_MV_R1_AC1;
                    OP_MV_AC_RP: nextState = S_MV_AC_RP1;
                    OP_MV_AC_RQ: nextState = S_MV_AC_RQ1;
                    OP_MV_AC_RL: nextState = S_MV_AC_RL1;
                    default:     nextState = S_IDLE;   // illegal byte, back to idle
                endcase
            end

            S_END1:    nextState = S_END1;   // held until reset

            S_LDIAC1:  nextState = S_LDIAC2;
            S_LDIAC2:  nextState = S_LDIAC3;
            S_LDAC1:   nextState = S_LDAC2;
            S_STR1:    nextState = S_STR2;
            S_STIR1:   nextState = S_STIR2;
            S_STIR2:   nextState = S_STIR3;
            S_JUMP1:   nextState = S_JUMP2;
            S_JMPNZY1: nextState = S_JMPNZY2;
            S_JMPZY1:  nextState = S_JMPZY2;

            // last state of every instruction
            S_NOP1, S_CLAC1, S_LDIAC3, S_LDAC2, S_STR2, S_STIR3,
            S_JUMP2, S_JMPNZY2, S_JMPNZN1, S_JMPZY2, S_JMPZN1,
            S_MUL1, S_ADD1, S_SUB1, S_INCAC1,
            S_MV_RL_AC1, S_MV_RP_AC1, S_MV_RQ_AC1, S_MV_RC_AC1, S_MV_R_AC1,
            S_MV_R1_AC1, S_MV_AC_RP1, S_MV_AC_RQ1, S_MV_AC_RL1: nextState = S_FETCH;

            default:   nextState = S_IDLE;
        endcase
    end

endmodule

// ==== logic/controlRom.sv ====
`timescale 1ns/1ps

module controlRom (
    input  controlPkg::state_t    state,
    output controlPkg::ctrlWord_t ctrl,
    output logic                  ready,
    output logic                  done
);
    import controlPkg::*;

    always_comb begin
        ctrl = IDLE_WORD;
        case (state)
            S_FETCH:  ctrl.wrEn.ir = 1'b1;
            S_DECODE: begin
                ctrl.inc.pc  = 1'b1;
                ctrl.busSel  = BUS_DMEM;
            end
            S_END1:   ctrl.busSel = BUS_DMEM;
            S_CLAC1:  begin
                ctrl.aluOp   = ALU_CLR;
                ctrl.wrEn.ac = 1'b1;
                ctrl.zWrEn   = 1'b1;
            end

            S_LDIAC1, S_STIR1: ctrl.wrEn.ir = 1'b1;
            S_LDIAC2, S_STIR2: begin
                ctrl.wrEn.ar = 1'b1;
                ctrl.inc.pc  = 1'b1;
                ctrl.busSel  = BUS_IR;   // operand address from IR
            end
            S_LDAC1, S_STR1: begin
                ctrl.wrEn.ar = 1'b1;
                ctrl.busSel  = BUS_AC;
            end
            S_LDIAC3, S_LDAC2: begin
                ctrl.aluOp   = ALU_PASS;
                ctrl.wrEn.ac = 1'b1;
                ctrl.zWrEn   = 1'b1;
                ctrl.busSel  = BUS_DMEM;
            end
            S_STR2, S_STIR3: ctrl.dataMemWrEn = 1'b1;

            // jump target lands in IR, then moves to PC
            S_JUMP1, S_JMPNZY1, S_JMPZY1: begin
                ctrl.wrEn.ir = 1'b1;
                ctrl.busSel  = BUS_DMEM;
            end
            S_JUMP2, S_JMPNZY2, S_JMPZY2: begin
                ctrl.wrEn.pc = 1'b1;
                ctrl.busSel  = BUS_IR;
            end
            S_JMPNZN1, S_JMPZN1: ctrl.inc.pc = 1'b1;   // skip the operand

            S_MUL1: begin
                ctrl.aluOp   = ALU_MUL;
                ctrl.inc.rc  = 1'b1;
                ctrl.inc.rp  = 1'b1;
                ctrl.inc.rq  = 1'b1;
                ctrl.wrEn.ac = 1'b1;
                ctrl.zWrEn   = 1'b1;
                ctrl.busSel  = BUS_R1;
            end
            S_ADD1, S_SUB1, S_INCAC1: begin
                ctrl.wrEn.ac = 1'b1;
                ctrl.zWrEn   = 1'b1;
                ctrl.aluOp   = (state == S_ADD1) ? ALU_ADD :
                               (state == S_SUB1) ? ALU_SUB : ALU_INC;
                ctrl.busSel  = (state == S_ADD1) ? BUS_R :
                               (state == S_SUB1) ? BUS_RC : BUS_IDLE;
            end

            S_MV_RL_AC1, S_MV_RP_AC1, S_MV_RQ_AC1,
            S_MV_RC_AC1, S_MV_R_AC1, S_MV_R1_AC1: begin
                ctrl.busSel  = BUS_AC;
                ctrl.wrEn.rl = (state == S_MV_RL_AC1);
                ctrl.wrEn.rp = (state == S_MV_RP_AC1);
                ctrl.wrEn.rq = (state == S_MV_RQ_AC1);
                ctrl.wrEn.rc = (state == S_MV_RC_AC1);
                ctrl.wrEn.r  = (state == S_MV_R_AC1);
                ctrl.wrEn.r1 = (state == S_MV_R1_AC1);
            end
            S_MV_AC_RP1, S_MV_AC_RQ1, S_MV_AC_RL1: begin
                ctrl.aluOp   = ALU_PASS;
                ctrl.wrEn.ac = 1'b1;
                ctrl.zWrEn   = 1'b1;
                ctrl.busSel  = (state == S_MV_AC_RP1) ? BUS_RP :
                               (state == S_MV_AC_RQ1) ? BUS_RQ : BUS_RL;
            end

            default: ctrl = IDLE_WORD;   // idle and no-op
        endcase
    end

    assign ready = (state == S_IDLE);
    assign done  = (state == S_END1);

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module controlUnit (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      start,
    input  logic                      zOut,
    input  logic [`CPU_INS_WIDTH-1:0] ins,
    output controlPkg::ctrlWord_t     ctrl,
    output logic                      ready,
    output logic                      done
);
    import controlPkg::*;

    opcode_t opcode;
    state_t  state;

    opcodeDecoder decoder_i (
        .ins    (ins),
        .opcode (opcode)
    );

    sequencer sequencer_i (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .zOut   (zOut),
        .opcode (opcode),
        .state  (state)
    );

    controlRom rom_i (
        .state (state),
        .ctrl  (ctrl),
        .ready (ready),
        .done  (done)
    );

endmodule

// ==== tb/controlUnit_properties.sv ====
`timescale 1ns/1ps

module controlUnit_properties (
    input logic                  clk,
    input logic                  rstN,
    input controlPkg::ctrlWord_t ctrl,
    input logic                  ready,
    input logic                  done
);
    int failCount = 0;

    readyDone: assert property (@(posedge clk) disable iff (!rstN) !(ready && done))
        else begin
            failCount++;
            $error("ready and done are high in the same cycle");
        end

    // a memory write never loads a register on the same cycle
    memWrite: assert property (@(posedge clk) disable iff (!rstN)
                               ctrl.dataMemWrEn |-> (ctrl.wrEn == '0))
        else begin
            failCount++;
            $error("data memory write together with a register write enable");
        end

    resetIdle: assert property (@(posedge clk) !rstN |=> ready)
        else begin
            failCount++;
            $error("ready low after a reset cycle");
        end

endmodule

bind controlUnit controlUnit_properties props_i (
    .clk(clk), .rstN(rstN), .ctrl(ctrl), .ready(ready), .done(done)
);

// ==== tb/controlUnit_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module controlUnit_tb;
    import controlPkg::*;

    localparam int NUM_ROWS    = 24;
    localparam int NUM_ILLEGAL = 20;
    localparam int TIMEOUT_NS  = ((NUM_ROWS + NUM_ILLEGAL + 1) * 6 + 40) * 10;

    // one-hot fields in wrEnSel_t bit order: ar r pc ir rl rc rp rq r1 ac
    localparam logic [9:0] W_AR = 10'b1000000000;
    localparam logic [9:0] W_R  = 10'b0100000000;
    localparam logic [9:0] W_PC = 10'b0010000000;
    localparam logic [9:0] W_IR = 10'b0001000000;
    localparam logic [9:0] W_RL = 10'b0000100000;
    localparam logic [9:0] W_RC = 10'b0000010000;
    localparam logic [9:0] W_RP = 10'b0000001000;
    localparam logic [9:0] W_RQ = 10'b0000000100;
    localparam logic [9:0] W_R1 = 10'b0000000010;
    localparam logic [9:0] W_AC = 10'b0000000001;
    localparam logic [3:0] I_PC = 4'b1000;   // incSel_t order: pc rc rp rq

    typedef struct {
        string                     name;
        logic [`CPU_INS_WIDTH-1:0] ins;
        logic                      z;
        int                        n;
        ctrlWord_t [0:2]           w;
    } row_t;

    logic                      clk;
    logic                      rstN;
    logic                      start;
    logic                      zOut;
    logic [`CPU_INS_WIDTH-1:0] ins;
    ctrlWord_t                 ctrl;
    logic                      ready;
    logic                      done;

    row_t                      rows [NUM_ROWS];
    logic [`CPU_INS_WIDTH-1:0] illegal [NUM_ILLEGAL];
    int                        numRows = 0;
    int                        wordErrors = 0;
    int                        flagErrors = 0;
    int                        countErrors = 0;
    integer                    seed = 99295;
    ctrlWord_t                 fetchWord;
    ctrlWord_t                 decodeWord;

    controlUnit dut_i (.clk(clk), .rstN(rstN), .start(start), .zOut(zOut), .ins(ins),
                       .ctrl(ctrl), .ready(ready), .done(done));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the DUT never reached the end", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    function automatic ctrlWord_t makeWord(aluOp_t a, logic [3:0] i, logic [9:0] w,
                                           busSel_t b, logic m, logic z);
        ctrlWord_t c;
        c.aluOp       = a;
        c.inc         = incSel_t'(i);
        c.wrEn        = wrEnSel_t'(w);
        c.busSel      = b;
        c.dataMemWrEn = m;
        c.zWrEn       = z;
        return c;
    endfunction

    // result lands in AC and updates Z
    function automatic ctrlWord_t accWord(aluOp_t a, busSel_t b);
        return makeWord(a, 4'b0000, W_AC, b, 1'b0, 1'b1);
    endfunction

    function automatic ctrlWord_t moveWord(logic [9:0] w);
        return makeWord(ALU_IDLE, 4'b0000, w, BUS_AC, 1'b0, 1'b0);
    endfunction

    function automatic logic isLegal(logic [7:0] b);
        return (b <= 8'd13) || (b[3:0] == `CPU_MV_LOW && b[7:4] >= 4'd1 && b[7:4] <= 4'd9);
    endfunction

    task automatic addRow(string name, logic [7:0] b, logic z, int n,
                          ctrlWord_t w0, ctrlWord_t w1, ctrlWord_t w2);
        rows[numRows] = '{name, b, z, n, {w0, w1, w2}};
        numRows++;
    endtask

    task automatic checkWord(string name, ctrlWord_t exp, ctrlWord_t act);
        if (act !== exp) begin
            wordErrors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            flagErrors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkCount(string name, int exp, int act);
        if (act != exp) begin
            countErrors++;
            $display("CHECK FAILED %s length: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic nextCycle;
        @(posedge clk);
        #1;
    endtask

    task automatic driveRow(int r);
        ins  = (r < NUM_ROWS) ? rows[r].ins : illegal[0];   // illegal bytes follow the table
        zOut = (r < NUM_ROWS) ? rows[r].z : 1'b0;
    endtask

    // entered at the decode cycle of row r; leaves at the next decode cycle
    task automatic runRow(int r);
        int   steps;
        logic found;
        steps = 0;
        found = 1'b0;
        while (!found && steps < 8) begin
            nextCycle();
            steps++;
            if (steps == rows[r].n + 1)
                driveRow(r + 1);
            @(negedge clk);
            if (steps <= rows[r].n)
                checkWord(rows[r].name, rows[r].w[steps-1], ctrl);
            else if (steps == rows[r].n + 1)
                checkWord({rows[r].name, " fetch"}, fetchWord, ctrl);
            found = (steps > rows[r].n) && (ctrl === decodeWord);
        end
        checkCount(rows[r].name, rows[r].n, steps - 2);
    endtask

    initial begin
        ctrlWord_t wIr, wArIr, wArAc, wMem, wJmp1, wJmp2, wSkip, wEnd;
        int rnd;
        rstN  = 1'b0;
        start = 1'b0;
        zOut  = 1'b0;
        ins   = '0;
        fetchWord  = makeWord(ALU_IDLE, 4'b0000, W_IR, BUS_IDLE, 1'b0, 1'b0);
        decodeWord = makeWord(ALU_IDLE, I_PC, '0, BUS_DMEM, 1'b0, 1'b0);
        wIr   = fetchWord;
        wArIr = makeWord(ALU_IDLE, I_PC, W_AR, BUS_IR, 1'b0, 1'b0);
        wArAc = makeWord(ALU_IDLE, 4'b0000, W_AR, BUS_AC, 1'b0, 1'b0);
        wMem  = makeWord(ALU_IDLE, 4'b0000, '0, BUS_IDLE, 1'b1, 1'b0);
        wJmp1 = makeWord(ALU_IDLE, 4'b0000, W_IR, BUS_DMEM, 1'b0, 1'b0);
        wJmp2 = makeWord(ALU_IDLE, 4'b0000, W_PC, BUS_IR, 1'b0, 1'b0);
        wSkip = makeWord(ALU_IDLE, I_PC, '0, BUS_IDLE, 1'b0, 1'b0);
        wEnd  = makeWord(ALU_IDLE, 4'b0000, '0, BUS_DMEM, 1'b0, 1'b0);

        addRow("nop", 8'h00, 1'b0, 1, IDLE_WORD, IDLE_WORD, IDLE_WORD);
        addRow("clac", 8'h02, 1'b0, 1, accWord(ALU_CLR, BUS_IDLE), IDLE_WORD, IDLE_WORD);
        addRow("ldiac", 8'h03, 1'b0, 3, wIr, wArIr, accWord(ALU_PASS, BUS_DMEM));
        addRow("ldac", 8'h04, 1'b0, 2, wArAc, accWord(ALU_PASS, BUS_DMEM), IDLE_WORD);
        addRow("str", 8'h05, 1'b0, 2, wArAc, wMem, IDLE_WORD);
        addRow("stir", 8'h06, 1'b0, 3, wIr, wArIr, wMem);
        addRow("jump", 8'h07, 1'b0, 2, wJmp1, wJmp2, IDLE_WORD);
        addRow("jmpnz taken", 8'h08, 1'b0, 2, wJmp1, wJmp2, IDLE_WORD);
        addRow("jmpnz skip", 8'h08, 1'b1, 1, wSkip, IDLE_WORD, IDLE_WORD);
        addRow("jmpz taken", 8'h09, 1'b1, 2, wJmp1, wJmp2, IDLE_WORD);
        addRow("jmpz skip", 8'h09, 1'b0, 1, wSkip, IDLE_WORD, IDLE_WORD);
        addRow("mul", 8'h0a, 1'b0, 1,
               makeWord(ALU_MUL, 4'b0111, W_AC, BUS_R1, 1'b0, 1'b1), IDLE_WORD, IDLE_WORD);
        addRow("add", 8'h0b, 1'b0, 1, accWord(ALU_ADD, BUS_R), IDLE_WORD, IDLE_WORD);
        addRow("sub", 8'h0c, 1'b0, 1, accWord(ALU_SUB, BUS_RC), IDLE_WORD, IDLE_WORD);
        addRow("incac", 8'h0d, 1'b0, 1, accWord(ALU_INC, BUS_IDLE), IDLE_WORD, IDLE_WORD);
        addRow("mv rl,ac", 8'h1f, 1'b0, 1, moveWord(W_RL), IDLE_WORD, IDLE_WORD);
        addRow("mv rp,ac", 8'h2f, 1'b0, 1, moveWord(W_RP), IDLE_WORD, IDLE_WORD);
        addRow("mv rq,ac", 8'h3f, 1'b0, 1, moveWord(W_RQ), IDLE_WORD, IDLE_WORD);
        addRow("mv rc,ac", 8'h4f, 1'b0, 1, moveWord(W_RC), IDLE_WORD, IDLE_WORD);
        addRow("mv r,ac", 8'h5f, 1'b0, 1, moveWord(W_R), IDLE_WORD, IDLE_WORD);
        addRow("mv r1,ac", 8'h6f, 1'b0, 1, moveWord(W_R1), IDLE_WORD, IDLE_WORD);
        addRow("mv ac,rp", 8'h7f, 1'b0, 1, accWord(ALU_PASS, BUS_RP), IDLE_WORD, IDLE_WORD);
        addRow("mv ac,rq", 8'h8f, 1'b0, 1, accWord(ALU_PASS, BUS_RQ), IDLE_WORD, IDLE_WORD);
        addRow("mv ac,rl", 8'h9f, 1'b0, 1, accWord(ALU_PASS, BUS_RL), IDLE_WORD, IDLE_WORD);

        for (int k = 0; k < NUM_ILLEGAL; k++) begin
            do begin
                rnd = $random(seed);
                illegal[k] = rnd[7:0];
            end while (isLegal(illegal[k]));
        end

        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checkFlag("idle ready", 1'b1, ready);
            checkFlag("idle done", 1'b0, done);
            checkWord("idle", IDLE_WORD, ctrl);
        end

        nextCycle();
        start = 1'b1;   // left high, so an illegal byte restarts at once
        driveRow(0);
        nextCycle();
        @(negedge clk);
        checkWord("start fetch", fetchWord, ctrl);
        checkFlag("fetch ready", 1'b0, ready);
        nextCycle();
        @(negedge clk);
        checkWord("start decode", decodeWord, ctrl);

        for (int r = 0; r < NUM_ROWS; r++)
            runRow(r);

        for (int k = 0; k < NUM_ILLEGAL; k++) begin
            nextCycle();
            ins = (k + 1 < NUM_ILLEGAL) ? illegal[k+1] : 8'h01;   // end instruction comes last
            @(negedge clk);
            checkFlag($sformatf("illegal %h ready", illegal[k]), 1'b1, ready);
            checkWord($sformatf("illegal %h idle", illegal[k]), IDLE_WORD, ctrl);
            nextCycle();
            @(negedge clk);
            checkWord("illegal refetch", fetchWord, ctrl);
            nextCycle();
            @(negedge clk);
            checkWord("illegal redecode", decodeWord, ctrl);
        end

        repeat (10) begin
            nextCycle();
            @(negedge clk);
            checkFlag("end done", 1'b1, done);
            checkFlag("end ready", 1'b0, ready);
            checkWord("end", wEnd, ctrl);
        end
        nextCycle();
        rstN = 1'b0;
        nextCycle();
        rstN = 1'b1;
        @(negedge clk);
        checkFlag("reset ready", 1'b1, ready);
        checkFlag("reset done", 1'b0, done);

        $display("errors: %0d word, %0d flag, %0d count, %0d assertion",
                 wordErrors, flagErrors, countErrors, dut_i.props_i.failCount);
        if (wordErrors + flagErrors + countErrors + dut_i.props_i.failCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/sequencer.sv
logic/controlRom.sv
logic/controlUnit.sv
tb/controlUnit_properties.sv
tb/controlUnit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnit_tb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
